// ==== dv/clock_gen.sv ====
`timescale 1ns/1ps
`default_nettype none

module clock_gen #(
  parameter int PERIOD_NS = 40
) (
  output logic clk
);

  initial clk = 1'b0;

  always #(PERIOD_NS / 2) clk = ~clk;

endmodule

`default_nettype wire

// ==== dv/frame_dbuf_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module frame_dbuf_tb
  import frame_dbuf_pkg::*;
();

  localparam int H_VIS = 8;
  localparam int H_TOTAL = 12;
  localparam int V_VIS = 4;
  localparam int V_TOTAL = 7;
  localparam int RESET_CYCLES = 8;
  localparam int DRIVE_DELAY = 2;
  localparam int MAX_TESTS = 32;
  localparam int MARGIN_CYCLES = 2000;

  logic        clk;
  logic        reset;
  seed_t       seed;
  logic        take;
  logic        out_valid;
  video_word_t out_word;

  // test table with three hex values per entry
  logic [7:0]  test_raw [3*MAX_TESTS];
  seed_t       test_seed [MAX_TESTS];
  int          test_hold [MAX_TESTS];
  int          test_pct [MAX_TESTS];
  int          num_tests;
  bit          tests_loaded;
  logic [31:0] rng_state;

  // model of the raster position, counted from taken words
  int          col_m;
  int          row_m;
  seed_t       frame_blue;
  int          seed_idx;
  int          test_idx;
  int          frames_in_test;
  int          frames_total;
  int          word_errors;
  int          seed_errors;
  int          other_errors;

  clock_gen #(.PERIOD_NS(40)) u_clk (.clk(clk));

  frame_dbuf_top #(
    .H_VIS(H_VIS), .H_TOTAL(H_TOTAL), .V_VIS(V_VIS), .V_TOTAL(V_TOTAL),
    .FIFO_DEPTH(16), .ALMOST_FULL_LEVEL(8)
  ) u_dut (
    .clk(clk), .reset(reset), .seed(seed), .take(take),
    .out_valid(out_valid), .out_word(out_word)
  );

  function automatic logic [31:0] xorshift32(input logic [31:0] state);
    logic [31:0] x;
    x = state;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  // sync low at two columns and two lines past the visible edge
  function automatic video_word_t build_expected(input int col, input int row, input seed_t blue);
    video_word_t w;
    w.hsync = !((col == H_VIS + 1) || (col == H_VIS + 2));
    w.vsync = !((row == V_VIS + 1) || (row == V_VIS + 2));
    w.pixel = '0;
    if ((col < H_VIS) && (row < V_VIS)) begin
      w.pixel.red   = 4'((col + int'(blue)) % 16);
      w.pixel.green = 4'(row);
      w.pixel.blue  = blue;
    end
    return w;
  endfunction

  task automatic check_word(input video_word_t actual, input video_word_t expected);
    if (actual !== expected) begin
      word_errors++;
      $display("Fail at %0t ns: frame %0d line %0d col %0d got %b%b %h, expected %b%b %h",
               $time, frames_total, row_m, col_m, actual.hsync, actual.vsync, actual.pixel,
               expected.hsync, expected.vsync, expected.pixel);
    end
  endtask

  task automatic check_seed(input seed_t actual, input seed_t expected);
    if (actual !== expected) begin
      seed_errors++;
      $display("Fail at %0t ns: frame %0d shows seed %h, expected %h",
               $time, frames_total, actual, expected);
    end
  endtask

  task automatic load_tests();
    $readmemh("dv/frame_dbuf_tests.txt", test_raw);
    num_tests = 0;
    // a hold count of zero ends the table
    while ((num_tests < MAX_TESTS) && (test_raw[3*num_tests+1] !== 8'h00) &&
           !$isunknown(test_raw[3*num_tests+1])) begin
      test_seed[num_tests] = test_raw[3*num_tests][3:0];
      test_hold[num_tests] = int'(test_raw[3*num_tests+1]);
      test_pct[num_tests]  = int'(test_raw[3*num_tests+2]);
      num_tests++;
    end
  endtask

  task automatic consume_word(input video_word_t got);
    int    idx;
    int    last;
    bit    found;
    seed_t want;
    // at a frame start the seed comes from the current entry or a later one already driven
    if ((col_m == 0) && (row_m == 0)) begin
      found = 1'b0;
      want  = test_seed[seed_idx];
      last  = (test_idx < num_tests) ? test_idx : num_tests - 1;
      for (idx = seed_idx; idx <= last; idx++) begin
        if (!found && (test_seed[idx] == got.pixel.blue)) begin
          found    = 1'b1;
          want     = test_seed[idx];
          seed_idx = idx;
        end
      end
      check_seed(got.pixel.blue, want);
      frame_blue = want;
    end
    check_word(got, build_expected(col_m, row_m, frame_blue));
    if (col_m == H_TOTAL - 1) begin
      col_m = 0;
      if (row_m == V_TOTAL - 1) begin
        row_m = 0;
        frames_total++;
        frames_in_test++;
        if (frames_in_test == test_hold[test_idx]) begin
          test_idx++;
          frames_in_test = 0;
        end
      end else begin
        row_m++;
      end
    end else begin
      col_m++;
    end
  endtask

  task automatic run_tests();
    int i;
    int cycles;
    bit seen_valid;
    cycles     = 0;
    seen_valid = 1'b0;
    for (i = 0; i < RESET_CYCLES; i++) begin
      @(posedge clk);
      #(DRIVE_DELAY);
      if (out_valid !== 1'b0) begin
        other_errors++;
        $display("Fail at %0t ns: out_valid was not low while reset was held", $time);
      end
    end
    reset = 1'b0;
    while (test_idx < num_tests) begin
      // outputs settle well before the falling edge
      @(negedge clk);
      if (!seen_valid && out_valid) begin
        seen_valid = 1'b1;
        if (cycles <= H_VIS * V_VIS) begin
          other_errors++;
          $display("Fail at %0t ns: out_valid rose %0d cycles after reset, before a full pattern",
                   $time, cycles);
        end
      end
      if (take && out_valid) begin
        consume_word(out_word);
      end
      @(posedge clk);
      #(DRIVE_DELAY);
      cycles++;
      take = 1'b0;
      if (test_idx < num_tests) begin
        seed      = test_seed[test_idx];
        rng_state = xorshift32(rng_state);
        take      = int'(rng_state % 32'd100) < test_pct[test_idx];
      end
    end
  endtask

  task automatic report_and_finish(input bit timed_out_run);
    $display("errors: %0d word, %0d seed, %0d other, %0d frames checked",
             word_errors, seed_errors, other_errors, frames_total);
    if (!timed_out_run && (word_errors == 0) && (seed_errors == 0) && (other_errors == 0)) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  endtask

  initial begin
    reset     = 1'b1;
    take      = 1'b0;
    seed      = '0;
    rng_state = 32'd49;
    load_tests();
    if (num_tests == 0) begin
      other_errors++;
      $display("no test entries could be read from dv/frame_dbuf_tests.txt");
      report_and_finish(1'b0);
    end else begin
      seed         = test_seed[0];
      tests_loaded = 1'b1;
      run_tests();
      report_and_finish(1'b0);
    end
  end

  // limit from the slowest take rate over all held frames
  initial begin
    int i;
    int total_hold;
    int min_pct;
    int limit;
    wait (tests_loaded);
    total_hold = 0;
    min_pct    = 100;
    for (i = 0; i < num_tests; i++) begin
      total_hold += test_hold[i];
      if (test_pct[i] < min_pct) min_pct = test_pct[i];
    end
    if (min_pct < 1) min_pct = 1;
    limit = total_hold * H_TOTAL * V_TOTAL * 2 * 100 / min_pct + MARGIN_CYCLES + RESET_CYCLES;
    repeat (limit) @(posedge clk);
    $display("timeout: the run did not finish within %0d cycles", limit);
    report_and_finish(1'b1);
  end

endmodule

`default_nettype wire

// ==== dv/frame_dbuf_tests.txt ====
// columns: seed, frames to hold it, take probability in percent; all values hex (64 = 100)
// the closing 0 0 0 line ends the table
3 02 64
a 01 50
5 02 32
c 01 0a
0 03 64
f 01 19
7 02 4b
1 01 0f
e 02 64
9 01 28
4 02 0a
b 01 5a
6 02 1e
2 01 64
d 03 14
8 01 46
3 02 0c
a 01 64
5 02 37
f 02 0a
0 00 00

// ==== frame_dbuf.f ====
src/frame_dbuf_pkg.sv
src/frame_buffer_switch.sv
src/pattern_writer.sv
src/pixel_streamer.sv
src/video_fifo.sv
src/frame_dbuf_top.sv
dv/clock_gen.sv
dv/frame_dbuf_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing -Wno-fatal --top-module frame_dbuf_tb \
  -f frame_dbuf.f -o sim_frame_dbuf
./obj_dir/sim_frame_dbuf 2>&1 | tee sim.log

if grep -q "Some tests failed" sim.log; then
  echo "simulation reported failures, see sim.log"
  exit 1
fi
echo "simulation finished without failures"

// ==== src/frame_buffer_switch.sv ====
`timescale 1ns/1ps
`default_nettype none

module frame_buffer_switch
  import frame_dbuf_pkg::*;
(
  input  logic              clk,
  input  logic              reset,
  input  logic              swap,

  // writer side
  input  wr_req_t           wr_req,
  input  logic              wr_valid,
  output logic              wr_ready,

  // streamer side
  input  logic [ADDR_W-1:0] rd_addr,
  input  logic              rd_valid,
  output logic              rd_ready,
  output pixel_t            rd_data,
  output logic              rd_data_valid
);

  localparam int DEPTH = 2 ** ADDR_W;

  // two frame buffers, indexed by bank
  pixel_t mem [2][DEPTH];

  // bank the writer owns, the streamer reads the other one
  logic   bank_sel;

  logic   wr_fire;
  logic   rd_fire;

  // on-chip write never stalls
  assign wr_ready = 1'b1;

  assign wr_fire = wr_valid && wr_ready;
  assign rd_fire = rd_valid && rd_ready;

  // storage and registered read port
  always_ff @(posedge clk) begin
    if (wr_fire) begin
      mem[bank_sel][wr_req.addr] <= wr_req.pixel;
    end
    if (rd_fire) begin
      rd_data <= mem[~bank_sel][rd_addr];
    end
  end

  // bank select flips on every swap
  // the read bank holds no frame until the first swap,
  // so rd_ready stays low until then
  always_ff @(posedge clk) begin
    if (reset) begin
      bank_sel      <= 1'b0;
      rd_ready      <= 1'b0;
      rd_data_valid <= 1'b0;
    end else begin
      // data comes back exactly one cycle after the request
      rd_data_valid <= rd_fire;
      if (swap) begin
        bank_sel <= ~bank_sel;
        rd_ready <= 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

// ==== src/frame_dbuf_pkg.sv ====
`default_nettype none

package frame_dbuf_pkg;

  // buffer address width, holds the largest visible area
  localparam int ADDR_W = 7;

  // pattern seed from the outside
  typedef logic [3:0] seed_t;

  // raster coordinates, sized for the largest supported frame
  typedef logic [3:0] coord_x_t;
  typedef logic [2:0] coord_y_t;

  // 12 bit rgb pixel
  typedef struct packed {
    logic [3:0] red;
    logic [3:0] green;
    logic [3:0] blue;
  } pixel_t;

  // fifo payload and top level output, syncs are active low
  typedef struct packed {
    logic   hsync;
    logic   vsync;
    pixel_t pixel;
  } video_word_t;

  // writer to buffer switch
  typedef struct packed {
    logic [ADDR_W-1:0] addr;
    pixel_t            pixel;
  } wr_req_t;

endpackage

`default_nettype wire

// ==== src/frame_dbuf_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module frame_dbuf_top
  import frame_dbuf_pkg::*;
#(
  parameter int H_VIS             = 8,
  parameter int H_TOTAL           = 12,
  parameter int V_VIS             = 4,
  parameter int V_TOTAL           = 7,
  parameter int FIFO_DEPTH        = 16,
  parameter int ALMOST_FULL_LEVEL = 8
) (
  input  logic        clk,
  input  logic        reset,
  input  seed_t       seed,
  input  logic        take,
  output logic        out_valid,
  output video_word_t out_word
);

  wr_req_t           wr_req;
  logic              wr_valid;
  logic              wr_ready;
  logic [ADDR_W-1:0] rd_addr;
  logic              rd_valid;
  logic              rd_ready;
  pixel_t            rd_data;
  logic              rd_data_valid;
  logic              pattern_done;
  logic              first_done;
  logic              first_done_q;
  logic              vsync_q;
  logic              vsync_fall;
  logic              swap;
  logic              stream_enable;
  logic              stream_push;
  video_word_t       stream_word;
  logic              fifo_empty;
  logic              fifo_almost_full;

  assign vsync_fall    = vsync_q && !stream_word.vsync;
  assign stream_enable = first_done && !fifo_almost_full;
  assign out_valid     = !fifo_empty;

  // first swap once the first pattern lands, then once per frame
  // at the start of vertical sync
  always_ff @(posedge clk) begin
    if (reset) begin
      first_done   <= 1'b0;
      first_done_q <= 1'b0;
      vsync_q      <= 1'b1;
      swap         <= 1'b0;
    end else begin
      if (pattern_done) first_done <= 1'b1;
      first_done_q <= first_done;
      vsync_q      <= stream_word.vsync;
      swap         <= (first_done && !first_done_q) || vsync_fall;
    end
  end

  frame_buffer_switch u_switch (
    .clk(clk), .reset(reset), .swap(swap),
    .wr_req(wr_req), .wr_valid(wr_valid), .wr_ready(wr_ready),
    .rd_addr(rd_addr), .rd_valid(rd_valid), .rd_ready(rd_ready),
    .rd_data(rd_data), .rd_data_valid(rd_data_valid)
  );

  pattern_writer #(.H_VIS(H_VIS), .V_VIS(V_VIS)) u_writer (
    .clk(clk), .reset(reset), .restart(swap), .seed(seed),
    .wr_req(wr_req), .wr_valid(wr_valid), .wr_ready(wr_ready), .done(pattern_done)
  );

  pixel_streamer #(
    .H_VIS(H_VIS), .H_TOTAL(H_TOTAL), .V_VIS(V_VIS), .V_TOTAL(V_TOTAL)
  ) u_streamer (
    .clk(clk), .reset(reset), .enable(stream_enable),
    .rd_addr(rd_addr), .rd_valid(rd_valid), .rd_ready(rd_ready),
    .rd_data(rd_data), .rd_data_valid(rd_data_valid),
    .push(stream_push), .word(stream_word)
  );

  video_fifo #(
    .T(video_word_t), .DEPTH(FIFO_DEPTH), .ALMOST_FULL_LEVEL(ALMOST_FULL_LEVEL)
  ) u_fifo (
    .clk(clk), .reset(reset), .push(stream_push), .push_data(stream_word),
    .pop(take), .head(out_word), .empty(fifo_empty), .almost_full(fifo_almost_full)
  );

endmodule

`default_nettype wire

// ==== src/pattern_writer.sv ====
`timescale 1ns/1ps
`default_nettype none

module pattern_writer
  import frame_dbuf_pkg::*;
#(
  parameter int H_VIS = 8,
  parameter int V_VIS = 4
) (
  input  logic    clk,
  input  logic    reset,
  input  logic    restart,
  input  seed_t   seed,
  output wr_req_t wr_req,
  output logic    wr_valid,
  input  logic    wr_ready,
  output logic    done
);

  coord_x_t x;
  coord_y_t y;
  seed_t    seed_q;
  pixel_t   pixel;
  logic     kick;
  logic     start;
  logic     last_col;
  logic     last_pixel;

  // first frame starts on its own once reset is released
  assign start      = restart || kick;
  assign last_col   = (x == coord_x_t'(H_VIS - 1));
  assign last_pixel = last_col && (y == coord_y_t'(V_VIS - 1));

  // red walks with x, offset by the seed
  always_comb begin
    pixel.red   = x + seed_q;
    pixel.green = 4'(y);
    pixel.blue  = seed_q;
  end

  assign wr_req = '{
    addr:  ADDR_W'(y) * ADDR_W'(H_VIS) + ADDR_W'(x),
    pixel: pixel
  };

  always_ff @(posedge clk) begin
    if (start) begin
      seed_q <= seed;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      kick     <= 1'b1;
      wr_valid <= 1'b0;
      done     <= 1'b0;
      x        <= '0;
      y        <= '0;
    end else if (start) begin
      kick     <= 1'b0;
      wr_valid <= 1'b1;
      done     <= 1'b0;
      x        <= '0;
      y        <= '0;
    end else if (wr_valid && wr_ready) begin
      if (last_pixel) begin
        wr_valid <= 1'b0;
        done     <= 1'b1;
      end else if (last_col) begin
        x <= '0;
        y <= y + 1'b1;
      end else begin
        x <= x + 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

// ==== src/pixel_streamer.sv ====
`timescale 1ns/1ps
`default_nettype none

module pixel_streamer
  import frame_dbuf_pkg::*;
#(
  parameter int H_VIS   = 8,
  parameter int H_TOTAL = 12,
  parameter int V_VIS   = 4,
  parameter int V_TOTAL = 7
) (
  input  logic              clk,
  input  logic              reset,
  input  logic              enable,

  // buffer read request
  output logic [ADDR_W-1:0] rd_addr,
  output logic              rd_valid,
  input  logic              rd_ready,
  input  pixel_t            rd_data,
  input  logic              rd_data_valid,

  // video words towards the fifo
  output logic              push,
  output video_word_t       word
);

  typedef enum logic {
    S_IDLE,
    S_WAIT
  } state_t;

  state_t   state;
  coord_x_t col;
  coord_y_t row;
  coord_x_t col_next;
  coord_y_t row_next;
  logic     visible;
  logic     hsync_n;
  logic     vsync_n;

  assign visible = (col < coord_x_t'(H_VIS)) && (row < coord_y_t'(V_VIS));

  // sync pulses two positions wide, one position after the visible edge
  assign hsync_n = !((col == coord_x_t'(H_VIS + 1)) || (col == coord_x_t'(H_VIS + 2)));
  assign vsync_n = !((row == coord_y_t'(V_VIS + 1)) || (row == coord_y_t'(V_VIS + 2)));

  // one outstanding read, only from idle at a visible position
  assign rd_valid = (state == S_IDLE) && enable && visible;
  assign rd_addr  = ADDR_W'(row) * ADDR_W'(H_VIS) + ADDR_W'(col);

  // raster position after the current one
  always_comb begin
    col_next = col + 1'b1;
    row_next = row;
    if (col == coord_x_t'(H_TOTAL - 1)) begin
      col_next = '0;
      if (row == coord_y_t'(V_TOTAL - 1)) begin
        row_next = '0;
      end else begin
        row_next = row + 1'b1;
      end
    end
  end

  // word keeps its last value between pushes, top watches its vsync
  always_ff @(posedge clk) begin
    if (reset) begin
      state <= S_IDLE;
      col   <= '0;
      row   <= '0;
      push  <= 1'b0;
      word  <= '{hsync: 1'b1, vsync: 1'b1, pixel: '0};
    end else begin
      push <= 1'b0;
      case (state)
        S_IDLE: begin
          if (enable) begin
            if (!visible) begin
              // blanking, no fetch needed
              push <= 1'b1;
              word <= '{hsync: hsync_n, vsync: vsync_n, pixel: '0};
              col  <= col_next;
              row  <= row_next;
            end else if (rd_ready) begin
              state <= S_WAIT;
            end
          end
        end
        S_WAIT: begin
          if (rd_data_valid) begin
            push  <= 1'b1;
            word  <= '{hsync: hsync_n, vsync: vsync_n, pixel: rd_data};
            col   <= col_next;
            row   <= row_next;
            state <= S_IDLE;
          end
        end
        default: state <= S_IDLE;
      endcase
    end
  end

endmodule

`default_nettype wire

// ==== src/video_fifo.sv ====
`timescale 1ns/1ps
`default_nettype none

module video_fifo #(
  parameter type T                 = logic [7:0],
  parameter int  DEPTH             = 16,
  parameter int  ALMOST_FULL_LEVEL = 8
) (
  input  logic clk,
  input  logic reset,
  input  logic push,
  input  T     push_data,
  input  logic pop,
  output T     head,
  output logic empty,
  output logic almost_full
);

  localparam int PTR_W = $clog2(DEPTH);
  localparam int CNT_W = $clog2(DEPTH + 1);

  T                 mem [DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;
  logic             full;
  logic             do_push;
  logic             do_pop;

  function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
    return (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + 1'b1;
  endfunction

  assign full        = (count == CNT_W'(DEPTH));
  assign empty       = (count == '0);
  assign almost_full = (count >= CNT_W'(ALMOST_FULL_LEVEL));

  // pops on empty and pushes on full are dropped
  assign do_push = push && !full;
  assign do_pop  = pop && !empty;

  // head reads straight from the array
  assign head = mem[rd_ptr];

  always_ff @(posedge clk) begin
    if (do_push) begin
      mem[wr_ptr] <= push_data;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_push) wr_ptr <= ptr_inc(wr_ptr);
      if (do_pop) rd_ptr <= ptr_inc(rd_ptr);
      if (do_push && !do_pop) begin
        count <= count + 1'b1;
      end else if (do_pop && !do_push) begin
        count <= count - 1'b1;
      end
    end
  end

endmodule

`default_nettype wire
